// ==== source/tile_macros.svh ====
// Tile memory network widths, device map and sizing
// Shared by the tile package and every block behind the command port

`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Bus widths
`define TILE_PADDR_W 32
`define TILE_DATA_W 64
`define TILE_TAG_W 4
`define TILE_DEV_W 4

// Everything below this address is a local device
`define TILE_DRAM_BASE 32'h8000_0000

// Local device ids in the dev field
`define TILE_DEV_MEM 4'd0
`define TILE_DEV_CLINT 4'd1
`define TILE_DEV_CFG 4'd2

// Storage sizes
`define TILE_MEM_WORDS 256
`define TILE_CFG_REGS 8

// Commands in flight between issue and response
`define TILE_ORDER_DEPTH 4

`endif

// ==== source/tile_pkg.sv ====
// Tile memory network types
// Command, response and routed command formats plus the address views

`include "tile_macros.svh"

package tile_pkg;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // Local device view of a physical address
  typedef struct packed {
    logic [7:0]                                  unused;
    logic [`TILE_DEV_W-1:0]                      dev;
    logic [`TILE_PADDR_W-8-`TILE_DEV_W-1:0]      offset;
  } local_addr_t;

  // Same word seen flat or split by device
  typedef union packed {
    logic [`TILE_PADDR_W-1:0] raw;
    local_addr_t              lcl;
  } paddr_u;

  typedef enum logic [1:0] {
    sel_mem   = 2'd0,
    sel_clint = 2'd1,
    sel_cfg   = 2'd2,
    sel_loop  = 2'd3
  } dev_sel_e;

  typedef struct packed {
    mem_op_e                op;
    paddr_u                 addr;
    logic [`TILE_DATA_W-1:0] data;
    logic [`TILE_TAG_W-1:0]  tag;
  } mem_cmd_t;

  typedef struct packed {
    mem_op_e                op;
    logic [`TILE_TAG_W-1:0]  tag;
    logic [`TILE_DATA_W-1:0] data;
  } mem_resp_t;

  typedef struct packed {
    mem_cmd_t cmd;
    dev_sel_e dst;
  } routed_cmd_t;

endpackage

// ==== source/cmd_decode.sv ====
// Command decode stage
// Registers each accepted command together with its target device

`include "tile_macros.svh"

module cmd_decode (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tile_pkg::mem_cmd_t    cmd_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  output tile_pkg::routed_cmd_t routed_o,
  output logic                  routed_valid_o,
  input  logic                  routed_ready_i
);

  import tile_pkg::*;

  paddr_u      cmd_addr;
  dev_sel_e    dst;
  routed_cmd_t routed_q;
  logic        valid_q;
  logic        accept;

  assign cmd_addr = cmd_i.addr;

  always_comb begin
    if (cmd_addr.raw >= `TILE_DRAM_BASE) begin
      dst = sel_mem;
    end else begin
      case (cmd_addr.lcl.dev)
        `TILE_DEV_MEM:   dst = sel_mem;
        `TILE_DEV_CFG:   dst = sel_cfg;
        `TILE_DEV_CLINT: dst = sel_clint;
        default:         dst = sel_loop;
      endcase
    end
  end

  // Take a new command when empty or draining this cycle
  assign cmd_ready_o = ~valid_q | routed_ready_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (routed_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      routed_q <= '{cmd: cmd_i, dst: dst};
    end
  end

  assign routed_o       = routed_q;
  assign routed_valid_o = valid_q;

  // Stalled output must hold until the crossbar takes it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    routed_valid_o && !routed_ready_i |=> routed_valid_o && $stable(routed_o))
    else $error("cmd_decode: routed command changed while stalled");

endmodule

// ==== source/dev_xbar.sv ====
// Device crossbar
// Issues routed commands to devices, keeps issue order in a small queue,
// answers loopback commands and returns responses in order

`include "tile_macros.svh"

module dev_xbar (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tile_pkg::routed_cmd_t routed_i,
  input  logic                  routed_valid_i,
  output logic                  routed_ready_o,
  output tile_pkg::mem_cmd_t    dev_cmd_o,
  output logic                  mem_valid_o,
  input  logic                  mem_ready_i,
  input  tile_pkg::mem_resp_t   mem_resp_i,
  input  logic                  mem_resp_valid_i,
  output logic                  mem_resp_ready_o,
  output logic                  cfg_valid_o,
  input  logic                  cfg_ready_i,
  input  tile_pkg::mem_resp_t   cfg_resp_i,
  input  logic                  cfg_resp_valid_i,
  output logic                  cfg_resp_ready_o,
  output logic                  clint_valid_o,
  input  logic                  clint_ready_i,
  input  tile_pkg::mem_resp_t   clint_resp_i,
  input  logic                  clint_resp_valid_i,
  output logic                  clint_resp_ready_o,
  output tile_pkg::mem_resp_t   resp_o,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i
);

  import tile_pkg::*;

  localparam int DEPTH = `TILE_ORDER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  dev_sel_e               order_q [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]         count_q;
  logic                   full, push, pop;
  logic                   loop_valid_q, loop_ready, loop_take;
  mem_op_e                loop_op_q;
  logic [`TILE_TAG_W-1:0] loop_tag_q;
  logic [3:0]             dev_ready, dev_issue, dev_resp_v, resp_rdy, resp_take;
  logic [3:0]             queued;
  mem_resp_t              dev_resp [4];
  dev_sel_e               head_sel;
  logic                   head_vld;

  assign full = (count_q == DEPTH[PTR_W:0]);

  // Indexed by dev_sel_e
  assign dev_ready = {loop_ready, cfg_ready_i, clint_ready_i, mem_ready_i};
  assign dev_issue = {4{routed_valid_i & ~full}} & (4'b0001 << routed_i.dst);

  assign dev_cmd_o     = routed_i.cmd;
  assign mem_valid_o   = dev_issue[sel_mem];
  assign clint_valid_o = dev_issue[sel_clint];
  assign cfg_valid_o   = dev_issue[sel_cfg];

  assign routed_ready_o = ~full & dev_ready[routed_i.dst];
  assign push           = routed_valid_i & routed_ready_o;

  // Head of the order queue picks the response source
  assign head_sel = order_q[rd_ptr_q];
  assign head_vld = (count_q != '0);

  assign dev_resp_v = {loop_valid_q, cfg_resp_valid_i, clint_resp_valid_i, mem_resp_valid_i};

  always_comb begin
    dev_resp[sel_mem]   = mem_resp_i;
    dev_resp[sel_clint] = clint_resp_i;
    dev_resp[sel_cfg]   = cfg_resp_i;
    dev_resp[sel_loop]  = '{op: loop_op_q, tag: loop_tag_q, data: '0};
  end

  assign resp_o       = dev_resp[head_sel];
  assign resp_valid_o = head_vld & dev_resp_v[head_sel];
  assign pop          = resp_valid_o & resp_ready_i;

  assign resp_rdy  = {4{resp_ready_i & head_vld}} & (4'b0001 << head_sel);
  assign resp_take = resp_rdy & dev_resp_v;

  assign mem_resp_ready_o   = resp_rdy[sel_mem];
  assign clint_resp_ready_o = resp_rdy[sel_clint];
  assign cfg_resp_ready_o   = resp_rdy[sel_cfg];

  // One-entry loopback slot
  assign loop_take  = resp_take[sel_loop];
  assign loop_ready = ~loop_valid_q | loop_take;

  // Devices that still own an entry in the order queue
  always_comb begin
    queued = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (i < int'(count_q)) begin
        queued[order_q[PTR_W'(rd_ptr_q + i)]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      loop_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
      if (push && routed_i.dst == sel_loop) begin
        loop_valid_q <= 1'b1;
      end else if (loop_take) begin
        loop_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= routed_i.dst;
    end
    if (push && routed_i.dst == sel_loop) begin
      loop_op_q  <= routed_i.cmd.op;
      loop_tag_q <= routed_i.cmd.tag;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_q <= DEPTH[PTR_W:0])
    else $error("dev_xbar: order queue overflow");

  // Every pending device response still has its entry in the order queue
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (dev_resp_v & ~queued) == 4'b0000)
    else $error("dev_xbar: response outside issue order");

endmodule

// ==== source/cfg_regs.sv ====
// Configuration register file
// Register 0 reports the tile device id, the rest are scratch registers

`include "tile_macros.svh"

module cfg_regs (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  tile_pkg::mem_cmd_t  cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_t resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  input  logic [15:0]         did_i
);

  import tile_pkg::*;

  localparam int IDX_W = $clog2(`TILE_CFG_REGS);

  logic [`TILE_DATA_W-1:0] regs_q [1:`TILE_CFG_REGS-1];
  logic [IDX_W-1:0]        idx;
  logic [`TILE_DATA_W-1:0] rdata;
  logic                    accept;
  logic                    resp_valid_q;
  mem_resp_t               resp_q;

  assign idx         = cmd_i.addr.raw[IDX_W+2:3];
  assign cmd_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  // Register 0 is the device id and is read only
  assign rdata = (idx == '0) ? {{(`TILE_DATA_W-16){1'b0}}, did_i} : regs_q[idx];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
      for (int i = 1; i < `TILE_CFG_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (accept && cmd_i.op == op_write && idx != '0) begin
        regs_q[idx] <= cmd_i.data;
      end
      if (accept) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= '{op: cmd_i.op, tag: cmd_i.tag,
                  data: (cmd_i.op == op_write) ? '0 : rdata};
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

// ==== source/clint_slice.sv ====
// Timer and interrupt block
// Free-running mtime, mtimecmp and msip with timer and software interrupts

`include "tile_macros.svh"

module clint_slice (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  tile_pkg::mem_cmd_t  cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_t resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output logic                timer_irq_o,
  output logic                software_irq_o
);

  import tile_pkg::*;

  localparam logic [19:0] OFF_MSIP     = 20'h0_0000;
  localparam logic [19:0] OFF_MTIMECMP = 20'h0_4000;
  localparam logic [19:0] OFF_MTIME    = 20'h0_bff8;

  logic [`TILE_DATA_W-1:0] mtime_q, mtimecmp_q, rdata;
  logic                    msip_q, timer_irq_q;
  logic                    accept, wr;
  logic                    resp_valid_q;
  mem_resp_t               resp_q;

  assign cmd_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = cmd_valid_i & cmd_ready_o;
  assign wr          = accept & (cmd_i.op == op_write);

  always_comb begin
    case (cmd_i.addr.lcl.offset)
      OFF_MSIP:     rdata = {{(`TILE_DATA_W-1){1'b0}}, msip_q};
      OFF_MTIMECMP: rdata = mtimecmp_q;
      OFF_MTIME:    rdata = mtime_q;
      default:      rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q      <= '0;
      mtimecmp_q   <= '1;
      msip_q       <= 1'b0;
      timer_irq_q  <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      mtime_q     <= mtime_q + 1'b1;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      if (wr && cmd_i.addr.lcl.offset == OFF_MSIP) begin
        msip_q <= cmd_i.data[0];
      end
      if (wr && cmd_i.addr.lcl.offset == OFF_MTIMECMP) begin
        mtimecmp_q <= cmd_i.data;
      end
      if (accept) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= '{op: cmd_i.op, tag: cmd_i.tag, data: wr ? '0 : rdata};
    end
  end

  assign resp_o         = resp_q;
  assign resp_valid_o   = resp_valid_q;
  assign timer_irq_o    = timer_irq_q;
  assign software_irq_o = msip_q;

endmodule

// ==== source/mem_bank.sv ====
// Single-cycle memory bank
// One 64-bit word per command, indexed by address bits [10:3]

`include "tile_macros.svh"

module mem_bank (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  tile_pkg::mem_cmd_t  cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_t resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i
);

  import tile_pkg::*;

  logic [`TILE_DATA_W-1:0] mem_q [`TILE_MEM_WORDS];
  logic [7:0]              idx;
  logic                    accept;
  logic                    resp_valid_q;
  mem_resp_t               resp_q;

  // Word index comes from fixed address bits
  assign idx         = cmd_i.addr.raw[10:3];
  assign cmd_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (cmd_i.op == op_write) begin
        mem_q[idx] <= cmd_i.data;
      end
      resp_q <= '{op: cmd_i.op, tag: cmd_i.tag,
                  data: (cmd_i.op == op_write) ? '0 : mem_q[idx]};
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i |-> int'(idx) < `TILE_MEM_WORDS)
    else $error("mem_bank: word index out of range");

endmodule

// ==== source/tile_io.sv ====
// Tile memory network top
// Decode stage, device crossbar and the three tile devices

module tile_io (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic [15:0]         did_i,
  input  tile_pkg::mem_cmd_t  cmd_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  output tile_pkg::mem_resp_t resp_o,
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output logic                timer_irq_o,
  output logic                software_irq_o
);

  import tile_pkg::*;

  routed_cmd_t routed;
  logic        routed_valid, routed_ready;
  mem_cmd_t    dev_cmd;

  logic      mem_valid, mem_ready, mem_resp_valid, mem_resp_ready;
  logic      cfg_valid, cfg_ready, cfg_resp_valid, cfg_resp_ready;
  logic      clint_valid, clint_ready, clint_resp_valid, clint_resp_ready;
  mem_resp_t mem_resp, cfg_resp, clint_resp;

  cmd_decode i_decode (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_i          (cmd_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .routed_o       (routed),
    .routed_valid_o (routed_valid),
    .routed_ready_i (routed_ready)
  );

  dev_xbar i_xbar (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .routed_i           (routed),
    .routed_valid_i     (routed_valid),
    .routed_ready_o     (routed_ready),
    .dev_cmd_o          (dev_cmd),
    .mem_valid_o        (mem_valid),
    .mem_ready_i        (mem_ready),
    .mem_resp_i         (mem_resp),
    .mem_resp_valid_i   (mem_resp_valid),
    .mem_resp_ready_o   (mem_resp_ready),
    .cfg_valid_o        (cfg_valid),
    .cfg_ready_i        (cfg_ready),
    .cfg_resp_i         (cfg_resp),
    .cfg_resp_valid_i   (cfg_resp_valid),
    .cfg_resp_ready_o   (cfg_resp_ready),
    .clint_valid_o      (clint_valid),
    .clint_ready_i      (clint_ready),
    .clint_resp_i       (clint_resp),
    .clint_resp_valid_i (clint_resp_valid),
    .clint_resp_ready_o (clint_resp_ready),
    .resp_o             (resp_o),
    .resp_valid_o       (resp_valid_o),
    .resp_ready_i       (resp_ready_i)
  );

  cfg_regs i_cfg (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (dev_cmd),
    .cmd_valid_i  (cfg_valid),
    .cmd_ready_o  (cfg_ready),
    .resp_o       (cfg_resp),
    .resp_valid_o (cfg_resp_valid),
    .resp_ready_i (cfg_resp_ready),
    .did_i        (did_i)
  );

  clint_slice i_clint (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_i          (dev_cmd),
    .cmd_valid_i    (clint_valid),
    .cmd_ready_o    (clint_ready),
    .resp_o         (clint_resp),
    .resp_valid_o   (clint_resp_valid),
    .resp_ready_i   (clint_resp_ready),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  mem_bank i_mem (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (dev_cmd),
    .cmd_valid_i  (mem_valid),
    .cmd_ready_o  (mem_ready),
    .resp_o       (mem_resp),
    .resp_valid_o (mem_resp_valid),
    .resp_ready_i (mem_resp_ready)
  );

endmodule

// ==== test/tile_model.sv ====
// Reference model of the tile devices and the address decode
// Predicts every response in issue order for the testbench

`include "tile_macros.svh"

module tile_model;

  timeunit 1ns;
  timeprecision 1ps;

  import tile_pkg::*;

  logic [`TILE_DATA_W-1:0] mem_m [`TILE_MEM_WORDS];
  bit                      mem_known [`TILE_MEM_WORDS];
  logic [`TILE_DATA_W-1:0] cfg_m [`TILE_CFG_REGS];
  logic                    msip_m;
  logic [`TILE_DATA_W-1:0] mtimecmp_m;
  mem_resp_t               exp_q [$];
  bit                      chk_q [$];
  bit                      time_q [$];

  function automatic void init(logic [15:0] did);
    for (int i = 0; i < `TILE_MEM_WORDS; i++) begin
      mem_known[i] = 1'b0;
    end
    cfg_m[0] = {{(`TILE_DATA_W-16){1'b0}}, did};
    for (int i = 1; i < `TILE_CFG_REGS; i++) begin
      cfg_m[i] = '0;
    end
    msip_m     = 1'b0;
    mtimecmp_m = '1;
    exp_q.delete();
    chk_q.delete();
    time_q.delete();
  endfunction

  // Bits [23:20] select the local device below the DRAM base
  function automatic dev_sel_e route(logic [31:0] a);
    if (a >= `TILE_DRAM_BASE) begin
      return sel_mem;
    end
    case (a[23:20])
      `TILE_DEV_MEM:   return sel_mem;
      `TILE_DEV_CFG:   return sel_cfg;
      `TILE_DEV_CLINT: return sel_clint;
      default:         return sel_loop;
    endcase
  endfunction

  function automatic void predict(mem_cmd_t cmd);
    mem_resp_t   r;
    bit          chk;
    bit          is_time;
    bit          wr;
    int          idx;
    logic [19:0] off;
    r       = '{op: cmd.op, tag: cmd.tag, data: '0};
    chk     = 1'b1;
    is_time = 1'b0;
    wr      = (cmd.op == op_write);
    off     = cmd.addr.raw[19:0];
    case (route(cmd.addr.raw))
      sel_mem: begin
        idx = int'(cmd.addr.raw[10:3]);
        if (wr) begin
          mem_m[idx]     = cmd.data;
          mem_known[idx] = 1'b1;
        end else if (mem_known[idx]) begin
          r.data = mem_m[idx];
        end else begin
          chk = 1'b0;
        end
      end
      sel_cfg: begin
        idx = int'(cmd.addr.raw[5:3]);
        if (wr && idx != 0) begin
          cfg_m[idx] = cmd.data;
        end else if (!wr) begin
          r.data = cfg_m[idx];
        end
      end
      sel_clint: begin
        if (wr && off == 20'h0_0000) begin
          msip_m = cmd.data[0];
        end else if (wr && off == 20'h0_4000) begin
          mtimecmp_m = cmd.data;
        end else if (!wr && off == 20'h0_0000) begin
          r.data = {{(`TILE_DATA_W-1){1'b0}}, msip_m};
        end else if (!wr && off == 20'h0_4000) begin
          r.data = mtimecmp_m;
        end else if (!wr && off == 20'h0_bff8) begin
          // mtime depends on timing so only the order of reads is compared
          chk     = 1'b0;
          is_time = 1'b1;
        end
      end
      default: begin
        r.data = '0;
      end
    endcase
    exp_q.push_back(r);
    chk_q.push_back(chk);
    time_q.push_back(is_time);
  endfunction

  function automatic bit pop_expected(output mem_resp_t r, output bit chk,
                                      output bit is_time);
    r       = '0;
    chk     = 1'b0;
    is_time = 1'b0;
    if (exp_q.size() == 0) begin
      return 1'b0;
    end
    r       = exp_q.pop_front();
    chk     = chk_q.pop_front();
    is_time = time_q.pop_front();
    return 1'b1;
  endfunction

  function automatic int pending();
    return exp_q.size();
  endfunction

endmodule

// ==== test/tile_tb.sv ====
// Tile memory network testbench
// Random commands under response back-pressure, checked against the tile model,
// plus directed config, interrupt and timer sequences

`include "tile_macros.svh"

module tile_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tile_pkg::*;

  localparam int          HALF_PERIOD   = 50;
  localparam logic [15:0] DEV_ID        = 16'h5a3c;
  localparam int          IDLE_LIMIT    = 20000;
  localparam int          IRQ_LIMIT     = 20;
  localparam logic [31:0] MSIP_ADDR     = 32'h0010_0000;
  localparam logic [31:0] MTIMECMP_ADDR = 32'h0010_4000;
  localparam logic [31:0] MTIME_ADDR    = 32'h0010_bff8;

  logic      clk_i;
  logic      arst_n_i;
  mem_cmd_t  cmd_i;
  logic      cmd_valid_i;
  logic      cmd_ready_o;
  mem_resp_t resp_o;
  logic      resp_valid_o;
  logic      resp_ready_i;
  logic      timer_irq_o;
  logic      software_irq_o;

  mem_cmd_t                send_q [$];
  logic [`TILE_DATA_W-1:0] mtime_q [$];
  logic [`TILE_TAG_W-1:0]  next_tag;
  bit                      held;
  int                      stretch;

  tile_io i_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .did_i          (DEV_ID),
    .cmd_i          (cmd_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .resp_o         (resp_o),
    .resp_valid_o   (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  tile_model i_model ();

  initial begin
    clk_i = 1'b0;
    forever #(HALF_PERIOD) clk_i = ~clk_i;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic void queue_cmd(mem_op_e op, logic [31:0] addr,
                                    logic [`TILE_DATA_W-1:0] data);
    mem_cmd_t c;
    c.op       = op;
    c.addr.raw = addr;
    c.data     = data;
    c.tag      = next_tag;
    next_tag   = next_tag + 1'b1;
    send_q.push_back(c);
  endfunction

  // Word index kept to 16 entries so reads often hit written words
  function automatic logic [31:0] rand_addr(int kind);
    logic [31:0] r;
    logic [7:0]  idx;
    r   = $urandom;
    idx = 8'($urandom % 16);
    case (kind)
      0:       return {1'b1, r[30:11], idx, r[2:0]};
      1:       return {1'b0, r[30:24], `TILE_DEV_MEM, r[19:11], idx, r[2:0]};
      2:       return {1'b0, r[30:24], `TILE_DEV_CFG, r[19:0]};
      default: return {1'b0, r[30:24], 4'(3 + $urandom % 13), r[19:0]};
    endcase
  endfunction

  task automatic check_resp();
    mem_resp_t exp;
    bit        chk;
    bit        is_time;
    bit        found;
    found = i_model.pop_expected(exp, chk, is_time);
    assert (found) else report_failure($sformatf(
      "Fail %0t: response with tag %0d but no command outstanding", $time, resp_o.tag));
    assert (resp_o.op == exp.op && resp_o.tag == exp.tag) else report_failure($sformatf(
      "Fail %0t: got op %0d tag %0d, expected op %0d tag %0d",
      $time, resp_o.op, resp_o.tag, exp.op, exp.tag));
    assert (!chk || resp_o.data == exp.data) else report_failure($sformatf(
      "Fail %0t: tag %0d data %h, expected %h", $time, exp.tag, resp_o.data, exp.data));
    if (is_time) begin
      mtime_q.push_back(resp_o.data);
    end
  endtask

  // Drive on the falling edge and sample the handshakes before the rising edge
  task automatic cycle();
    @(negedge clk_i);
    if (!held && send_q.size() != 0 && ($urandom % 4) != 0) begin
      cmd_i       = send_q.pop_front();
      cmd_valid_i = 1'b1;
      held        = 1'b1;
    end else if (!held) begin
      cmd_valid_i = 1'b0;
    end
    if (stretch == 0) begin
      resp_ready_i = ($urandom % 2) != 0;
      stretch      = 1 + int'($urandom % 12);
    end
    stretch--;
    #(HALF_PERIOD / 2);
    if (cmd_valid_i && cmd_ready_o) begin
      i_model.predict(cmd_i);
      held = 1'b0;
    end
    if (resp_valid_o && resp_ready_i) begin
      check_resp();
    end
  endtask

  task automatic drain(string what);
    int n;
    n = 0;
    while (held || send_q.size() != 0 || i_model.pending() != 0) begin
      assert (n < IDLE_LIMIT) else report_failure($sformatf(
        "Timed out after %0d cycles waiting for %s to complete", n, what));
      cycle();
      n++;
    end
  endtask

  task automatic wait_irq(bit timer, logic level, string what);
    int n;
    n = 0;
    while ((timer ? timer_irq_o : software_irq_o) !== level) begin
      assert (n < IRQ_LIMIT) else report_failure($sformatf(
        "Timed out after %0d cycles waiting for %s", n, what));
      cycle();
      n++;
    end
  endtask

  initial begin
    int      kind;
    mem_op_e op;
    void'($urandom(32'ha63));
    arst_n_i     = 1'b0;
    cmd_i        = '0;
    cmd_valid_i  = 1'b0;
    resp_ready_i = 1'b0;
    held         = 1'b0;
    stretch      = 0;
    next_tag     = '0;
    i_model.init(DEV_ID);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    assert (!resp_valid_o && !timer_irq_o && !software_irq_o) else report_failure(
      $sformatf("Fail %0t: response or interrupt active during reset", $time));
    arst_n_i = 1'b1;
    #(HALF_PERIOD / 2);
    assert (cmd_ready_o && !resp_valid_o && !timer_irq_o && !software_irq_o)
      else report_failure($sformatf("Fail %0t: wrong idle state after reset", $time));

    // Config registers before and after a write to register 0
    for (int r = 0; r < `TILE_CFG_REGS; r++) begin
      queue_cmd(op_read, {8'h00, `TILE_DEV_CFG, 14'h0, 3'(r), 3'h0}, '0);
    end
    queue_cmd(op_write, {8'h00, `TILE_DEV_CFG, 20'h0}, {$urandom, $urandom});
    queue_cmd(op_read, {8'h00, `TILE_DEV_CFG, 20'h0}, '0);
    drain("config register access");

    // Mixed memory, config and loopback traffic
    for (int i = 0; i < 400; i++) begin
      kind = int'($urandom % 4);
      op   = (($urandom % 2) != 0) ? op_write : op_read;
      queue_cmd(op, rand_addr(kind), {$urandom, $urandom});
    end
    drain("random traffic");

    queue_cmd(op_write, MSIP_ADDR, 64'h1);
    drain("msip set");
    wait_irq(1'b0, 1'b1, "software interrupt to rise");
    queue_cmd(op_read, MSIP_ADDR, '0);
    queue_cmd(op_write, MSIP_ADDR, 64'h0);
    drain("msip clear");
    wait_irq(1'b0, 1'b0, "software interrupt to fall");

    queue_cmd(op_write, MTIMECMP_ADDR, 64'h0);
    drain("mtimecmp clear");
    wait_irq(1'b1, 1'b1, "timer interrupt to rise");
    queue_cmd(op_read, MTIMECMP_ADDR, '0);
    queue_cmd(op_write, MTIMECMP_ADDR, '1);
    drain("mtimecmp set");
    wait_irq(1'b1, 1'b0, "timer interrupt to fall");

    mtime_q.delete();
    queue_cmd(op_read, MTIME_ADDR, '0);
    queue_cmd(op_read, MTIME_ADDR, '0);
    drain("mtime reads");
    assert (mtime_q.size() == 2)
      else report_failure("Two mtime reads did not return two values");
    assert (mtime_q[1] > mtime_q[0]) else report_failure($sformatf(
      "Fail %0t: mtime read %0d after %0d", $time, mtime_q[1], mtime_q[0]));

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+source
source/tile_pkg.sv
source/cmd_decode.sv
source/dev_xbar.sv
source/cfg_regs.sv
source/clint_slice.sv
source/mem_bank.sv
source/tile_io.sv
test/tile_model.sv
test/tile_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tile_tb \
  -Mdir obj_dir -o tile_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tile_tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
